// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int DEF_MUL_LATENCY = 4;
  localparam int DEF_WB_DEPTH    = 4;

  typedef logic [3:0] tag_t;

  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_BR  = 2'd1,
    UNIT_MUL = 2'd2
  } unit_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_type_t;

  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_type_t;

  typedef enum logic [1:0] {
    MUL_LO, MUL_H, MUL_HSU, MUL_HU
  } mul_type_t;

  // raw request from the issue port
  typedef struct packed {
    unit_t       unit;
    logic [2:0]  funct3;
    logic        alt;        // funct7 bit 5
    tag_t        tag;
    logic [31:0] src1;
    logic [31:0] src2;
  } exec_req_t;

  typedef struct packed {
    alu_type_t   alu_type;
    br_type_t    br_type;
    mul_type_t   mul_type;
    tag_t        tag;
    logic [31:0] src1;
    logic [31:0] src2;
  } micro_op_t;

  typedef struct packed {
    tag_t        tag;
    logic        is_branch;
    logic        taken;
    logic [31:0] data;
  } exec_result_t;

endpackage

`default_nettype wire

// File: issue_decode.sv
`timescale 1ns/10ps
`default_nettype none

module issue_decode import exec_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      issue_valid,
  input  wire exec_req_t issue_req,
  output micro_op_t      uop,
  output logic           alu_go,
  output logic           br_go,
  output logic           mul_go
);

  micro_op_t dec;

  always_comb begin
    dec.tag  = issue_req.tag;
    dec.src1 = issue_req.src1;
    dec.src2 = issue_req.src2;

    case (issue_req.funct3)
      3'b000:  dec.alu_type = issue_req.alt ? ALU_SUB : ALU_ADD;
      3'b001:  dec.alu_type = ALU_SLL;
      3'b010:  dec.alu_type = ALU_SLT;
      3'b011:  dec.alu_type = ALU_SLTU;
      3'b100:  dec.alu_type = ALU_XOR;
      3'b101:  dec.alu_type = issue_req.alt ? ALU_SRA : ALU_SRL;
      3'b110:  dec.alu_type = ALU_OR;
      default: dec.alu_type = ALU_AND;
    endcase

    case (issue_req.funct3)
      3'b001:  dec.br_type = BR_NE;
      3'b100:  dec.br_type = BR_LT;
      3'b101:  dec.br_type = BR_GE;
      3'b110:  dec.br_type = BR_LTU;
      3'b111:  dec.br_type = BR_GEU;
      default: dec.br_type = BR_EQ;    // 010/011 are not branches
    endcase

    case (issue_req.funct3)
      3'b001:  dec.mul_type = MUL_H;
      3'b010:  dec.mul_type = MUL_HSU;
      3'b011:  dec.mul_type = MUL_HU;
      default: dec.mul_type = MUL_LO;  // div codes fall back to mul
    endcase
  end

  always_ff @(posedge clock) begin
    if (issue_valid)
      uop <= dec;
  end

  // one strobe per valid issue
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_go <= 1'b0;
      br_go  <= 1'b0;
      mul_go <= 1'b0;
    end else begin
      alu_go <= issue_valid && (issue_req.unit == UNIT_ALU);
      br_go  <= issue_valid && (issue_req.unit == UNIT_BR);
      mul_go <= issue_valid && (issue_req.unit == UNIT_MUL);
    end
  end

endmodule

`default_nettype wire

// File: int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu import exec_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      go,
  input  wire micro_op_t uop,
  output logic           valid,
  output exec_result_t   result
);

  logic signed [31:0] s1, s2;
  logic        [4:0]  shamt;
  logic        [31:0] alu_data;

  assign s1    = uop.src1;
  assign s2    = uop.src2;
  assign shamt = uop.src2[4:0];

  always_comb begin
    case (uop.alu_type)
      ALU_ADD:  alu_data = uop.src1 + uop.src2;
      ALU_SUB:  alu_data = uop.src1 - uop.src2;
      ALU_SLT:  alu_data = {31'd0, s1 < s2};
      ALU_SLTU: alu_data = {31'd0, uop.src1 < uop.src2};
      ALU_XOR:  alu_data = uop.src1 ^ uop.src2;
      ALU_OR:   alu_data = uop.src1 | uop.src2;
      ALU_AND:  alu_data = uop.src1 & uop.src2;
      ALU_SLL:  alu_data = uop.src1 << shamt;
      ALU_SRL:  alu_data = uop.src1 >> shamt;
      ALU_SRA:  alu_data = s1 >>> shamt;   // keeps sign
      default:  alu_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (go) begin
      result.tag       <= uop.tag;
      result.is_branch <= 1'b0;
      result.taken     <= 1'b0;
      result.data      <= alu_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset)
      valid <= 1'b0;
    else
      valid <= go;
  end

endmodule

`default_nettype wire

// File: branch_cmp.sv
`timescale 1ns/10ps
`default_nettype none

module branch_cmp import exec_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      go,
  input  wire micro_op_t uop,
  output logic           valid,
  output exec_result_t   result
);

  logic signed [31:0] s1, s2;
  logic               taken;

  assign s1 = uop.src1;
  assign s2 = uop.src2;

  always_comb begin
    case (uop.br_type)
      BR_EQ:   taken = uop.src1 == uop.src2;
      BR_NE:   taken = uop.src1 != uop.src2;
      BR_LT:   taken = s1 < s2;
      BR_GE:   taken = s1 >= s2;
      BR_LTU:  taken = uop.src1 < uop.src2;
      BR_GEU:  taken = uop.src1 >= uop.src2;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (go) begin
      result.tag       <= uop.tag;
      result.is_branch <= 1'b1;
      result.taken     <= taken;
      result.data      <= '0;   // no data for branches
    end
  end

  always_ff @(posedge clock) begin
    if (reset)
      valid <= 1'b0;
    else
      valid <= go;
  end

endmodule

`default_nettype wire

// File: int_mul.sv
`timescale 1ns/10ps
`default_nettype none

module int_mul import exec_pkg::*; #(
  parameter int MUL_LATENCY = DEF_MUL_LATENCY
) (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      go,
  input  wire micro_op_t uop,
  output logic           valid,
  output exec_result_t   result
);

  logic                   a_signed;
  logic                   b_signed;
  logic signed [32:0]     op_a, op_b;
  logic signed [63:0]     product;
  logic [MUL_LATENCY-1:0] valid_q;
  logic [MUL_LATENCY-1:0] hi_q;      // upper word select per stage
  tag_t                   tag_q  [MUL_LATENCY];
  logic [63:0]            prod_q [MUL_LATENCY];

  always_comb begin
    case (uop.mul_type)
      MUL_HSU: begin
        a_signed = 1'b1;
        b_signed = 1'b0;
      end
      MUL_HU: begin
        a_signed = 1'b0;
        b_signed = 1'b0;
      end
      default: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
    endcase
  end

  // one extra bit so a single signed multiply covers all variants
  assign op_a    = {a_signed & uop.src1[31], uop.src1};
  assign op_b    = {b_signed & uop.src2[31], uop.src2};
  assign product = 64'(op_a) * 64'(op_b);

  always_ff @(posedge clock) begin
    prod_q[0] <= product;
    tag_q[0]  <= uop.tag;
    hi_q[0]   <= (uop.mul_type != MUL_LO);
    for (int i = 1; i < MUL_LATENCY; i++) begin
      prod_q[i] <= prod_q[i-1];
      tag_q[i]  <= tag_q[i-1];
      hi_q[i]   <= hi_q[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset)
      valid_q <= '0;
    else
      valid_q <= {valid_q[MUL_LATENCY-2:0], go};
  end

  assign valid = valid_q[MUL_LATENCY-1];

  always_comb begin
    result.tag       = tag_q[MUL_LATENCY-1];
    result.is_branch = 1'b0;
    result.taken     = 1'b0;
    result.data      = hi_q[MUL_LATENCY-1] ? prod_q[MUL_LATENCY-1][63:32]
                                           : prod_q[MUL_LATENCY-1][31:0];
  end

endmodule

`default_nettype wire

// File: writeback_queue.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_queue import exec_pkg::*; #(
  parameter int WB_DEPTH = DEF_WB_DEPTH
) (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire logic         a_valid,
  input  wire exec_result_t a_result,
  input  wire logic         b_valid,
  input  wire exec_result_t b_result,
  output logic              out_valid,
  output exec_result_t      out_result
);

  localparam int PTR_W = $clog2(WB_DEPTH);
  localparam int CNT_W = $clog2(WB_DEPTH + 1);

  exec_result_t     mem [WB_DEPTH];
  logic [PTR_W-1:0] rd_ptr, wr_ptr, wr_ptr_inc;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             first_v, second_v;
  exec_result_t     first_in;
  logic [1:0]       n_in, n_wr;
  logic             pop_v;
  exec_result_t     pop_data;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(WB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty      = (count == '0);
  assign first_v    = a_valid | b_valid;
  assign second_v   = a_valid & b_valid;
  assign first_in   = b_valid ? b_result : a_result;  // mul entry goes first
  assign n_in       = {1'b0, a_valid} + {1'b0, b_valid};
  assign pop_v      = !empty || first_v;
  assign pop_data   = empty ? first_in : mem[rd_ptr]; // bypass when empty
  assign n_wr       = empty ? {1'b0, second_v} : n_in;
  assign wr_ptr_inc = ptr_inc(wr_ptr);

  always_ff @(posedge clock) begin
    if (empty) begin
      if (second_v)
        mem[wr_ptr] <= a_result;
    end else begin
      if (first_v)
        mem[wr_ptr] <= first_in;
      if (second_v)
        mem[wr_ptr_inc] <= a_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (!empty)
        rd_ptr <= ptr_inc(rd_ptr);
      if (n_wr == 2'd1)
        wr_ptr <= wr_ptr_inc;
      else if (n_wr == 2'd2)
        wr_ptr <= ptr_inc(wr_ptr_inc);
      count     <= count + CNT_W'(n_in) - CNT_W'(pop_v);
      out_valid <= pop_v;
    end
  end

  always_ff @(posedge clock) begin
    if (pop_v)
      out_result <= pop_data;
  end

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit import exec_pkg::*; #(
  parameter int MUL_LATENCY = DEF_MUL_LATENCY,
  parameter int WB_DEPTH    = DEF_WB_DEPTH
) (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      issue_valid,
  input  wire exec_req_t issue_req,
  output logic           out_valid,
  output exec_result_t   out_result
);

  localparam int RES_W = $bits(exec_result_t);

  micro_op_t    uop;
  logic         alu_go, br_go, mul_go;
  logic         alu_valid, br_valid, mul_valid;
  exec_result_t alu_result, br_result, mul_result;
  logic         a_valid;
  exec_result_t a_result;

  issue_decode u_issue_decode (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .uop         (uop),
    .alu_go      (alu_go),
    .br_go       (br_go),
    .mul_go      (mul_go)
  );

  int_alu u_int_alu (
    .clock  (clock),
    .reset  (reset),
    .go     (alu_go),
    .uop    (uop),
    .valid  (alu_valid),
    .result (alu_result)
  );

  branch_cmp u_branch_cmp (
    .clock  (clock),
    .reset  (reset),
    .go     (br_go),
    .uop    (uop),
    .valid  (br_valid),
    .result (br_result)
  );

  int_mul #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_int_mul (
    .clock  (clock),
    .reset  (reset),
    .go     (mul_go),
    .uop    (uop),
    .valid  (mul_valid),
    .result (mul_result)
  );

  // alu and branch never finish together, so an and-or merge is enough
  assign a_valid  = alu_valid | br_valid;
  assign a_result = exec_result_t'(({RES_W{alu_valid}} & alu_result) |
                                   ({RES_W{br_valid}}  & br_result));

  writeback_queue #(
    .WB_DEPTH (WB_DEPTH)
  ) u_writeback_queue (
    .clock      (clock),
    .reset      (reset),
    .a_valid    (a_valid),
    .a_result   (a_result),
    .b_valid    (mul_valid),
    .b_result   (mul_result),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

// File: tb_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_unit import exec_pkg::*; ();

  localparam int MAX_OPS = 64;

  logic         clock;
  logic         reset;
  logic         issue_valid;
  exec_req_t    issue_req;
  logic         out_valid;
  exec_result_t out_result;

  logic [1:0]   op_unit   [MAX_OPS];
  logic [2:0]   op_funct3 [MAX_OPS];
  logic         op_alt    [MAX_OPS];
  logic [31:0]  op_src1   [MAX_OPS];
  logic [31:0]  op_src2   [MAX_OPS];
  logic [31:0]  op_exp    [MAX_OPS];
  int           num_ops;

  logic [15:0]  pending;      // one bit per outstanding tag
  logic         exp_branch [16];
  logic [31:0]  exp_value  [16];
  int           issued;
  int           received;
  int           errors;
  int           cycles;
  int           cycle_limit;
  integer       seed;

  exec_unit u_exec_unit (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .out_valid   (out_valid),
    .out_result  (out_result)
  );

  always #50 clock = ~clock;

  task automatic load_ops(output int count);
    int          fd;
    int          n;
    string       line;
    logic [31:0] u, f3, alt, s1, s2, ex;
    count = 0;
    fd = $fopen("exec_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open exec_testdata.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h", u, f3, alt, s1, s2, ex);
          if (n == 6 && count < MAX_OPS) begin
            op_unit[count]   = u[1:0];
            op_funct3[count] = f3[2:0];
            op_alt[count]    = alt[0];
            op_src1[count]   = s1;
            op_src2[count]   = s2;
            op_exp[count]    = ex;
            count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic issue_op(input int idx, input bit add_gaps);
    tag_t tag;
    int   gap;
    tag = tag_t'(idx % 16);
    while (pending[tag])  // tag still in flight
      @(negedge clock);
    issue_valid      = 1'b1;
    issue_req.unit   = unit_t'(op_unit[idx]);
    issue_req.funct3 = op_funct3[idx];
    issue_req.alt    = op_alt[idx];
    issue_req.tag    = tag;
    issue_req.src1   = op_src1[idx];
    issue_req.src2   = op_src2[idx];
    exp_branch[tag]  = (op_unit[idx] == 2'd1);
    exp_value[tag]   = op_exp[idx];
    pending[tag]     = 1'b1;
    issued++;
    @(negedge clock);
    issue_valid = 1'b0;
    if (add_gaps) begin
      gap = $random(seed) & 1;
      if (gap != 0)
        @(negedge clock);
    end
  endtask

  task automatic check_result(input exec_result_t res);
    logic        want_branch;
    logic        want_taken;
    logic [31:0] want_data;
    if (!pending[res.tag]) begin
      errors++;
      $display("result with tag %0d came back but no operation with that tag was in flight",
               res.tag);
    end else begin
      want_branch = exp_branch[res.tag];
      want_taken  = want_branch & exp_value[res.tag][0];
      want_data   = want_branch ? 32'h0 : exp_value[res.tag];
      if (res.is_branch !== want_branch) begin
        errors++;
        $display("ERROR out_result.is_branch tag %h got %h expected %h",
                 res.tag, res.is_branch, want_branch);
      end
      if (res.taken !== want_taken) begin
        errors++;
        $display("ERROR out_result.taken tag %h got %h expected %h",
                 res.tag, res.taken, want_taken);
      end
      if (res.data !== want_data) begin
        errors++;
        $display("ERROR out_result.data tag %h got %h expected %h",
                 res.tag, res.data, want_data);
      end
      pending[res.tag] = 1'b0;
      received++;
    end
  endtask

  // results sampled at the rising edge, before the DUT updates them
  always @(posedge clock) begin
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d results back", cycles, received, issued);
      $display("TEST FAILED");
      $finish;
    end else begin
      cycles = cycles + 1;
      if (reset) begin
        if (out_valid) begin
          errors++;
          $display("out_valid went high while reset was asserted");
        end
      end else if (out_valid) begin
        check_result(out_result);
      end
    end
  end

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_req   = '0;
    pending     = '0;
    issued      = 0;
    received    = 0;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 1000;
    seed        = 66473;
    load_ops(num_ops);
    if (num_ops == 0) begin
      $display("no operations were loaded from exec_testdata.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      cycle_limit = 20 * num_ops + 50;
      repeat (2) @(negedge clock);
      reset = 1'b0;
      repeat (3) @(negedge clock);  // idle, nothing may come out
      for (int i = 0; i < num_ops; i++)
        issue_op(i, 1'b1);
      // back to back, so mul and single-cycle results meet in the queue
      for (int i = 0; i < num_ops; i++)
        issue_op(i, 1'b0);
      while (received < issued)
        @(negedge clock);
      repeat (5) @(negedge clock);  // catch stray results
      $display("issued %0d, returned %0d, errors %0d", issued, received, errors);
      if (errors == 0 && received == issued)
        $display("TEST PASSED");
      else
        $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: exec_unit.f
exec_pkg.sv
issue_decode.sv
int_alu.sv
branch_cmp.sv
int_mul.sv
writeback_queue.sv
exec_unit.sv
tb_exec_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash

# build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_exec_unit \
  -f exec_unit.f -o sim_exec_unit
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: exec_testdata.txt
# unit funct3 alt src1 src2 expected, all hex
# unit 0 alu, 1 branch (expected is taken), 2 mul
0 0 0 00000005 00000007 0000000c
0 0 1 00000003 00000005 fffffffe
0 0 0 ffffffff 00000001 00000000
0 2 0 ffffffff 00000001 00000001
0 3 0 ffffffff 00000001 00000000
0 4 0 f0f0f0f0 0ff00ff0 ff00ff00
0 6 0 f0f0f0f0 0ff00ff0 fff0fff0
0 7 0 f0f0f0f0 0ff00ff0 00f000f0
0 1 0 00000001 00000024 00000010
0 5 0 80000000 00000004 08000000
0 5 1 80000000 00000004 f8000000
0 5 1 7ffffff0 00000021 3ffffff8
1 0 0 00000005 00000005 00000001
1 1 0 00000005 00000005 00000000
1 4 0 ffffffff 00000001 00000001
1 6 0 ffffffff 00000001 00000000
1 5 0 80000000 80000000 00000001
1 7 0 00000003 00000003 00000001
1 5 0 ffffffff 00000000 00000000
2 0 0 00000007 00000006 0000002a
0 0 1 00000000 00000001 ffffffff
1 7 0 ffffffff 00000000 00000001
2 1 0 80000000 ffffffff 00000000
0 1 0 12345679 0000001f 80000000
2 0 0 80000000 ffffffff 80000000
2 3 0 ffffffff ffffffff fffffffe
2 2 0 ffffffff ffffffff ffffffff
0 3 0 00000001 ffffffff 00000001
2 2 0 80000000 00000002 ffffffff
0 2 0 00000001 ffffffff 00000000
